/* hdl/cart_pkg.sv */
// Download beat layout, header field types and cheat record; addresses are byte offsets incl. a 512-byte copier header
package cart_pkg;

	// ========================================
	// Download stream
	// ========================================

	// One beat from the host loader
	typedef struct packed {
		logic        download;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [15:0] data;
		logic        wr;
	} load_bus_t;

	// All-ones index marks a cheat file rather than a cartridge image
	localparam logic [7:0] CODE_INDEX = 8'hFF;

	// Copier header in front of the image
	localparam logic [9:0] HEADER_SKIP = 10'd512;

	// ========================================
	// Cartridge header
	// ========================================

	typedef enum logic [2:0] {
		HDR_AUTO      = 3'd0,
		HDR_NO_HEADER = 3'd1,
		HDR_LOROM     = 3'd2,
		HDR_HIROM     = 3'd3,
		HDR_EXHIROM   = 3'd4
	} hdr_mode_t;

	typedef struct packed {
		logic [7:0]  rom_type;
		logic [23:0] rom_mask;
		logic [23:0] ram_mask;
	} rom_info_t;

	// Size word offsets in the download, RAM size word sits 2 bytes higher
	localparam logic [23:0] LOROM_SIZE_ADDR   = 24'h007FD6 + 24'(HEADER_SKIP);
	localparam logic [23:0] HIROM_SIZE_ADDR   = 24'h00FFD6 + 24'(HEADER_SKIP);
	localparam logic [23:0] EXHIROM_SIZE_ADDR = 24'h40FFD6 + 24'(HEADER_SKIP);

	// ========================================
	// Cheat codes
	// ========================================

	// Values arrive big endian, the code generator orders the bytes
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

/* hdl/backup_pkg.sv */
// SD block request and image status types; blocks are fixed at 512 bytes
package backup_pkg;

	// Block request towards the SD host, rd and wr held until ack rises
	typedef struct packed {
		logic [31:0] lba;
		logic        rd;
		logic        wr;
	} sd_req_t;

	// Save image state from the host
	typedef struct packed {
		// Pulse when an image is attached
		logic mounted;
		logic readonly;
		logic size_nonzero;
	} img_status_t;

	// log2 of the SD block size
	localparam int unsigned BLOCK_SHIFT = 9;

endpackage

/* hdl/rom_header_detect.sv */
// Header fields are taken from the raw download; masks settle two cycles after the last beat
`timescale 1ns/1ps

module rom_header_detect #(
	parameter int ADDR_W = 25
) (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  cart_pkg::load_bus_t  load,
	input  logic                 cart_download,
	input  cart_pkg::hdr_mode_t  hdr_mode,
	input  logic [1:0]           region_sel,
	output cart_pkg::rom_info_t  rom_info,
	output logic                 pal
);
	import cart_pkg::*;

	logic [ADDR_W-1:0] addr;
	logic [ADDR_W-1:0] size_addr;
	logic [ADDR_W-1:0] ram_addr;
	logic              forced;
	logic              beat;

	logic [7:0]  type_q;
	logic [3:0]  rom_size;
	logic [3:0]  ram_size;
	logic        rom_region;
	logic [23:0] rom_mask_q;
	logic [23:0] ram_mask_q;

	assign addr = load.addr[ADDR_W-1:0];
	assign beat = cart_download && load.wr;

	// Where the size words live for a forced layout
	always_comb begin
		forced    = 1'b1;
		size_addr = '0;
		case (hdr_mode)
			HDR_LOROM:   size_addr = ADDR_W'(LOROM_SIZE_ADDR);
			HDR_HIROM:   size_addr = ADDR_W'(HIROM_SIZE_ADDR);
			HDR_EXHIROM: size_addr = ADDR_W'(EXHIROM_SIZE_ADDR);
			default:     forced = 1'b0;
		endcase
	end

	assign ram_addr = size_addr + ADDR_W'(2);

	// ========================================
	// Header capture
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			type_q     <= 8'h00;
			rom_size   <= 4'hC;
			ram_size   <= 4'h0;
			rom_region <= 1'b0;
		end else if (beat) begin
			if (addr == '0) begin
				rom_size <= 4'hC;
				ram_size <= 4'h0;
				// Auto mode reads sizes packed in the first byte
				if (hdr_mode == HDR_AUTO && load.data[7:0] != 8'h00) begin
					{ram_size, rom_size} <= load.data[7:0];
				end
				case (hdr_mode)
					HDR_NO_HEADER, HDR_LOROM: type_q <= 8'h00;
					HDR_HIROM:                type_q <= 8'h01;
					HDR_EXHIROM:              type_q <= 8'h02;
					default:                  type_q <= load.data[15:8];
				endcase
			end
			if (addr == ADDR_W'(2)) begin
				rom_region <= load.data[8];
			end
			if (forced && addr == size_addr) begin
				rom_size <= load.data[11:8];
			end
			if (forced && addr == ram_addr) begin
				ram_size <= load.data[3:0];
			end
		end
	end

	// Size codes to masks, 1 KiB times 2^size
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_mask_q <= 24'd0;
			ram_mask_q <= 24'd0;
		end else begin
			rom_mask_q <= (24'd1024 << rom_size) - 24'd1;
			ram_mask_q <= (ram_size != 4'h0) ? (24'd1024 << ram_size) - 24'd1 : 24'd0;
		end
	end

	// Region only follows once the download is over
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			pal <= 1'b0;
		end else if (!cart_download) begin
			pal <= (region_sel == 2'd0) ? rom_region : region_sel[1];
		end
	end

	assign rom_info = '{rom_type: type_q, rom_mask: rom_mask_q, ram_mask: ram_mask_q};

endmodule

/* hdl/cheat_code_loader.sv */
// One cheat per 16-byte record; a record is only complete once offset 14 has been written
`timescale 1ns/1ps

module cheat_code_loader #(
	parameter int ADDR_W = 25
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  cart_pkg::load_bus_t   load,
	input  logic                  code_download,
	input  logic                  cart_download,
	output cart_pkg::cheat_code_t code,
	output logic                  cheat_valid,
	output logic                  cheat_reset
);

	logic beat;
	logic first_beat;

	assign beat       = code_download && load.wr;
	assign first_beat = beat && (load.addr[ADDR_W-1:0] == '0);

	// Core drops its cheat table on a new cart or a new cheat file
	assign cheat_reset = cart_download || first_beat;

	// Half-words land by low address bits, even offset is the low half
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			code        <= '0;
			cheat_valid <= 1'b0;
		end else begin
			cheat_valid <= 1'b0;
			if (beat) begin
				case (load.addr[3:0])
					4'd0:  code.flags[15:0]    <= load.data;
					4'd2:  code.flags[31:16]   <= load.data;
					4'd4:  code.addr[15:0]     <= load.data;
					4'd6:  code.addr[31:16]    <= load.data;
					4'd8:  code.compare[15:0]  <= load.data;
					4'd10: code.compare[31:16] <= load.data;
					4'd12: code.replace[15:0]  <= load.data;
					4'd14: begin
						code.replace[31:16] <= load.data;
						// Last half-word, hand the code over
						cheat_valid         <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

/* hdl/backup_ram_sync.sv */
// Backup RAM sequencer; waits on sd_ack with no timeout, last block capped by BK_BITS
`timescale 1ns/1ps

module backup_ram_sync #(
	parameter int BK_BITS = 17
) (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    cart_download,
	input  logic [23:0]             ram_mask,
	input  backup_pkg::img_status_t img,
	input  logic                    bk_load,
	input  logic                    bk_save,
	input  logic                    autosave,
	input  logic                    osd_open,
	input  logic                    bsram_write,
	input  logic                    sd_ack,
	output backup_pkg::sd_req_t     sd_req,
	output logic                    bk_busy,
	output logic                    bk_loading,
	output logic                    bk_pending
);
	import backup_pkg::*;

	typedef enum logic {
		ST_IDLE = 1'b0,
		ST_BUSY = 1'b1
	} state_t;

	state_t state;

	logic [BK_BITS-BLOCK_SHIFT-1:0] last_block;
	logic [31:0] lba;
	logic        rd;
	logic        wr;
	logic        bk_ena;
	logic        old_download;
	logic        old_load;
	logic        old_save;
	logic        old_ack;
	logic        save_req;
	logic        load_rise;
	logic        save_rise;
	logic        dl_end;
	logic        ack_rise;
	logic        ack_fall;

	// Masks are 2^n-1, so slicing caps the count at the RAM size
	assign last_block = ram_mask[BK_BITS-1:BLOCK_SHIFT];

	assign save_req  = bk_save || (bk_pending && osd_open && autosave);
	assign load_rise = bk_ena && bk_load && !old_load;
	assign save_rise = bk_ena && save_req && !old_save;
	assign dl_end    = bk_ena && old_download && !cart_download && img.size_nonzero;
	assign ack_rise  = sd_ack && !old_ack;
	assign ack_fall  = old_ack && !sd_ack;

	assign bk_busy = (state == ST_BUSY);
	assign sd_req  = '{lba: lba, rd: rd, wr: wr};

	// ========================================
	// Enable and pending flag
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			old_download <= 1'b0;
			bk_ena       <= 1'b0;
		end else begin
			old_download <= cart_download;
			if (cart_download && !old_download) begin
				bk_ena <= 1'b0;
			end
			// Save image is mounted by the host near the end of the download
			if (cart_download && img.mounted && !img.readonly) begin
				bk_ena <= (ram_mask != 24'd0);
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			bk_pending <= 1'b0;
		end else if (bk_ena && !osd_open && bsram_write) begin
			bk_pending <= 1'b1;
		end else if (bk_busy) begin
			bk_pending <= 1'b0;
		end
	end

	// ========================================
	// Block sequencer
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			state      <= ST_IDLE;
			bk_loading <= 1'b0;
			lba        <= 32'd0;
			rd         <= 1'b0;
			wr         <= 1'b0;
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
		end else begin
			old_load <= bk_load;
			old_save <= save_req;
			old_ack  <= sd_ack;

			// Host has taken the request
			if (ack_rise) begin
				rd <= 1'b0;
				wr <= 1'b0;
			end

			case (state)
				ST_IDLE: begin
					if (load_rise || save_rise) begin
						state      <= ST_BUSY;
						bk_loading <= load_rise;
						lba        <= 32'd0;
						rd         <= load_rise;
						wr         <= !load_rise;
					end
					// End of a cart download always reloads the save
					if (dl_end) begin
						state      <= ST_BUSY;
						bk_loading <= 1'b1;
						lba        <= 32'd0;
						rd         <= 1'b1;
						wr         <= 1'b0;
					end
				end
				ST_BUSY: begin
					if (ack_fall) begin
						if (lba >= 32'(last_block)) begin
							state      <= ST_IDLE;
							bk_loading <= 1'b0;
						end else begin
							lba <= lba + 32'd1;
							rd  <= bk_loading;
							wr  <= !bk_loading;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

/* hdl/cart_loader_top.sv */
// Cart loader top; the download index alone tells a cheat file from a cartridge image
`timescale 1ns/1ps

module cart_loader_top #(
	parameter int ADDR_W  = 25,
	parameter int BK_BITS = 17
) (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  cart_pkg::load_bus_t     load,
	input  cart_pkg::hdr_mode_t     hdr_mode,
	input  logic [1:0]              region_sel,
	input  backup_pkg::img_status_t img,
	input  logic                    bk_load,
	input  logic                    bk_save,
	input  logic                    autosave,
	input  logic                    osd_open,
	input  logic                    bsram_write,
	input  logic                    sd_ack,
	output cart_pkg::rom_info_t     rom_info,
	output logic                    pal,
	output cart_pkg::cheat_code_t   code,
	output logic                    cheat_valid,
	output logic                    cheat_reset,
	output backup_pkg::sd_req_t     sd_req,
	output logic                    bk_busy,
	output logic                    bk_loading,
	output logic                    core_reset,
	output logic                    led_user
);
	import cart_pkg::*;

	logic code_download;
	logic cart_download;
	logic bk_pending;

	// Index decode
	assign code_download = load.download && (load.index == CODE_INDEX);
	assign cart_download = load.download && (load.index != CODE_INDEX);

	// Core held while the image or its save is coming in
	assign core_reset = cart_download || bk_loading;
	assign led_user   = cart_download || (autosave && bk_pending);

	rom_header_detect #(
		.ADDR_W(ADDR_W)
	) u_header (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.load          (load),
		.cart_download (cart_download),
		.hdr_mode      (hdr_mode),
		.region_sel    (region_sel),
		.rom_info      (rom_info),
		.pal           (pal)
	);

	cheat_code_loader #(
		.ADDR_W(ADDR_W)
	) u_cheat (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.load          (load),
		.code_download (code_download),
		.cart_download (cart_download),
		.code          (code),
		.cheat_valid   (cheat_valid),
		.cheat_reset   (cheat_reset)
	);

	backup_ram_sync #(
		.BK_BITS(BK_BITS)
	) u_backup (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.ram_mask      (rom_info.ram_mask),
		.img           (img),
		.bk_load       (bk_load),
		.bk_save       (bk_save),
		.autosave      (autosave),
		.osd_open      (osd_open),
		.bsram_write   (bsram_write),
		.sd_ack        (sd_ack),
		.sd_req        (sd_req),
		.bk_busy       (bk_busy),
		.bk_loading    (bk_loading),
		.bk_pending    (bk_pending)
	);

endmodule

/* testbench/backup_checker.sv */
// SD request rules for backup_ram_sync; checked only while reset is released
`timescale 1ns/1ps

module backup_checker #(
	parameter int BK_BITS = 17
) (
	input logic                clk_sys,
	input logic                reset,
	input backup_pkg::sd_req_t sd_req,
	input logic                bk_busy,
	input logic [23:0]         ram_mask
);
	import backup_pkg::*;

	int          fail_count = 0;
	logic [31:0] last_block;

	assign last_block = 32'(ram_mask[BK_BITS-1:BLOCK_SHIFT]);

	// Read and write never requested together
	a_rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (!reset)
		!(sd_req.rd && sd_req.wr))
	else begin
		fail_count++;
		$error("SD read and write requested in the same cycle");
	end

	a_req_when_busy: assert property (@(posedge clk_sys) disable iff (!reset)
		(sd_req.rd || sd_req.wr) |-> bk_busy)
	else begin
		fail_count++;
		$error("SD request raised while the sequencer is idle");
	end

	// Block number stays inside the save RAM
	a_lba_in_range: assert property (@(posedge clk_sys) disable iff (!reset)
		bk_busy |-> (sd_req.lba <= last_block))
	else begin
		fail_count++;
		$error("SD block number beyond the last backup RAM block");
	end

endmodule

bind backup_ram_sync backup_checker #(
	.BK_BITS(BK_BITS)
) u_checker (
	.clk_sys (clk_sys),
	.reset   (reset),
	.sd_req  (sd_req),
	.bk_busy (bk_busy),
	.ram_mask(ram_mask)
);

/* testbench/cart_loader_tb.sv */
// Directed tests only; the SD host model acks 2 to 9 cycles after a request and holds ack 2 cycles
`timescale 1ns/1ps

module cart_loader_tb;
	import cart_pkg::*;
	import backup_pkg::*;

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 5;
	// Upper bounds over all tests for the watchdog
	localparam int N_BEATS      = 40;
	localparam int N_BLOCKS     = 32;
	localparam int BLOCK_CYCLES = 16;
	localparam int WATCHDOG_NS  =
		(RESET_CYCLES + 4 * N_BEATS + N_BLOCKS * BLOCK_CYCLES + 200) * CLK_PERIOD;
	localparam int START_LIMIT  = 8;
	localparam int BUSY_LIMIT   = 16 * BLOCK_CYCLES + START_LIMIT;

	logic        clk_sys = 1'b0;
	logic        reset;
	load_bus_t   load;
	hdr_mode_t   hdr_mode;
	logic [1:0]  region_sel;
	img_status_t img;
	logic        bk_load;
	logic        bk_save;
	logic        autosave;
	logic        osd_open;
	logic        bsram_write;
	logic        sd_ack;
	rom_info_t   rom_info;
	logic        pal;
	cheat_code_t code;
	logic        cheat_valid;
	logic        cheat_reset;
	sd_req_t     sd_req;
	logic        bk_busy;
	logic        bk_loading;
	logic        core_reset;
	logic        led_user;

	integer      seed = 32'hfa274fc9;
	int          ack_delay;
	int          errors = 0;
	int          checks = 0;
	int          valid_pulses = 0;
	logic [31:0] blk_lba[$];
	logic        blk_rd[$];

	cart_loader_top #(
		.ADDR_W (25),
		.BK_BITS(17)
	) u_dut (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.load       (load),
		.hdr_mode   (hdr_mode),
		.region_sel (region_sel),
		.img        (img),
		.bk_load    (bk_load),
		.bk_save    (bk_save),
		.autosave   (autosave),
		.osd_open   (osd_open),
		.bsram_write(bsram_write),
		.sd_ack     (sd_ack),
		.rom_info   (rom_info),
		.pal        (pal),
		.code       (code),
		.cheat_valid(cheat_valid),
		.cheat_reset(cheat_reset),
		.sd_req     (sd_req),
		.bk_busy    (bk_busy),
		.bk_loading (bk_loading),
		.core_reset (core_reset),
		.led_user   (led_user)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// ========================================
	// SD host model and monitors
	// ========================================

	// Logs each request and acks it after a random delay
	always begin
		@(negedge clk_sys);
		if (reset && (sd_req.rd || sd_req.wr)) begin
			blk_lba.push_back(sd_req.lba);
			blk_rd.push_back(sd_req.rd);
			ack_delay = 2 + int'($unsigned($random(seed)) % 32'd8);
			repeat (ack_delay) @(negedge clk_sys);
			sd_ack = 1'b1;
			repeat (2) @(negedge clk_sys);
			sd_ack = 1'b0;
		end
	end

	always @(negedge clk_sys) begin
		if (cheat_valid) begin
			valid_pulses++;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the tests did not finish in time");
		$display("*** TEST FAILED ***");
		$finish;
	end

	// ========================================
	// Helpers
	// ========================================

	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("ERR %s: expected %0h, actual %0h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic start_download(input logic [7:0] index);
		@(negedge clk_sys);
		load.download = 1'b1;
		load.index    = index;
		load.wr       = 1'b0;
	endtask

	task automatic send_word(input logic [24:0] addr, input logic [15:0] data);
		@(negedge clk_sys);
		load.addr = addr;
		load.data = data;
		load.wr   = 1'b1;
		@(negedge clk_sys);
		load.wr   = 1'b0;
	endtask

	task automatic end_download();
		@(negedge clk_sys);
		load.download = 1'b0;
		load.wr       = 1'b0;
	endtask

	// Follows one sequencer run until bk_busy falls
	task automatic wait_busy_done(input string name, input logic expect_loading);
		int   cycles;
		logic hold_ok;
		cycles  = 0;
		hold_ok = 1'b1;
		while (!bk_busy && cycles < START_LIMIT) begin
			@(negedge clk_sys);
			cycles++;
		end
		if (!bk_busy) begin
			$display("%s: block sequencer never became busy", name);
			errors++;
		end
		while (bk_busy && cycles < BUSY_LIMIT) begin
			if (bk_loading !== expect_loading || core_reset !== expect_loading) begin
				hold_ok = 1'b0;
			end
			@(negedge clk_sys);
			cycles++;
		end
		if (bk_busy) begin
			$display("%s: block sequencer still busy after %0d cycles", name, cycles);
			errors++;
		end
		check_value({name, " loading level"}, 128'(1), 128'(hold_ok));
	endtask

	task automatic check_blocks(input string name, input logic exp_rd, input int count);
		check_value({name, " block count"}, 128'(count), 128'(blk_lba.size()));
		for (int i = 0; i < blk_lba.size(); i++) begin
			check_value($sformatf("%s lba %0d", name, i), 128'(i), 128'(blk_lba[i]));
			check_value($sformatf("%s rd %0d", name, i), 128'(exp_rd), 128'(blk_rd[i]));
		end
	endtask

	task automatic forced_case(input string name, input hdr_mode_t mode,
		input logic [23:0] size_addr, input int rom_sz, input int ram_sz,
		input logic [7:0] exp_type, input logic [23:0] exp_rom_mask,
		input logic [23:0] exp_ram_mask);
		hdr_mode = mode;
		start_download(8'h00);
		send_word(25'd0, 16'h0000);
		send_word(25'(size_addr), {4'h0, 4'(rom_sz), 8'h00});
		send_word(25'(size_addr + 24'd2), {12'h000, 4'(ram_sz)});
		end_download();
		idle_cycles(3);
		check_value({name, " rom_type"}, 128'(exp_type), 128'(rom_info.rom_type));
		check_value({name, " rom_mask"}, 128'(exp_rom_mask), 128'(rom_info.rom_mask));
		check_value({name, " ram_mask"}, 128'(exp_ram_mask), 128'(rom_info.ram_mask));
	endtask

	// ========================================
	// Directed tests
	// ========================================

	task automatic auto_header();
		hdr_mode = HDR_AUTO;
		start_download(8'h00);
		send_word(25'd0, 16'h212B);
		end_download();
		idle_cycles(3);
		// 2 MiB ROM and 4 KiB RAM
		check_value("auto rom_type", 128'(8'h21), 128'(rom_info.rom_type));
		check_value("auto rom_mask", 128'(24'h1FFFFF), 128'(rom_info.rom_mask));
		check_value("auto ram_mask", 128'(24'h000FFF), 128'(rom_info.ram_mask));
	endtask

	task automatic forced_header();
		forced_case("lorom", HDR_LOROM, LOROM_SIZE_ADDR, 10, 3, 8'h00,
			24'h0FFFFF, 24'h001FFF);
		forced_case("hirom", HDR_HIROM, HIROM_SIZE_ADDR, 11, 5, 8'h01,
			24'h1FFFFF, 24'h007FFF);
	endtask

	task automatic region_select();
		hdr_mode   = HDR_AUTO;
		region_sel = 2'd0;
		start_download(8'h00);
		send_word(25'd0, 16'h0000);
		send_word(25'd2, 16'h0100);
		end_download();
		idle_cycles(2);
		check_value("region from header", 128'(1), 128'(pal));
		region_sel = 2'd1;
		idle_cycles(2);
		check_value("region forced ntsc", 128'(0), 128'(pal));
		region_sel = 2'd2;
		idle_cycles(2);
		check_value("region forced pal", 128'(1), 128'(pal));
		region_sel = 2'd0;
	endtask

	task automatic cheat_load();
		logic [15:0] words [8];
		int          pulses_before;
		words = '{16'h0001, 16'h8000, 16'h2345, 16'h007E, 16'h00AB, 16'h1200,
			16'h00CD, 16'h3400};
		pulses_before = valid_pulses;
		// Cart download alone asks the core to drop its cheats
		start_download(8'h00);
		#(CLK_PERIOD / 4);
		check_value("cheat_reset cart", 128'(1), 128'(cheat_reset));
		end_download();
		start_download(CODE_INDEX);
		@(negedge clk_sys);
		load.addr = 25'd0;
		load.data = words[0];
		load.wr   = 1'b1;
		#(CLK_PERIOD / 4);
		check_value("cheat_reset first beat", 128'(1), 128'(cheat_reset));
		@(negedge clk_sys);
		load.wr = 1'b0;
		#(CLK_PERIOD / 4);
		check_value("cheat_reset idle", 128'(0), 128'(cheat_reset));
		for (int i = 1; i < 8; i++) begin
			send_word(25'(2 * i), words[i]);
		end
		end_download();
		idle_cycles(2);
		check_value("cheat code", 128'({words[1], words[0], words[3], words[2],
			words[5], words[4], words[7], words[6]}), 128'(code));
		check_value("cheat valid pulses", 128'(1), 128'(valid_pulses - pulses_before));
	endtask

	task automatic auto_load();
		hdr_mode = HDR_AUTO;
		img      = '{mounted: 1'b0, readonly: 1'b0, size_nonzero: 1'b1};
		blk_lba.delete();
		blk_rd.delete();
		start_download(8'h00);
		// ROM size 8, RAM size 3
		send_word(25'd0, 16'h0038);
		idle_cycles(2);
		@(negedge clk_sys);
		img.mounted = 1'b1;
		@(negedge clk_sys);
		img.mounted = 1'b0;
		check_value("auto-load ram_mask", 128'(24'd8191), 128'(rom_info.ram_mask));
		end_download();
		wait_busy_done("auto-load", 1'b1);
		check_blocks("auto-load", 1'b1, 16);
		check_value("auto-load core_reset end", 128'(0), 128'(core_reset));
	endtask

	task automatic menu_autosave();
		autosave = 1'b1;
		osd_open = 1'b0;
		blk_lba.delete();
		blk_rd.delete();
		idle_cycles(1);
		check_value("autosave led idle", 128'(0), 128'(led_user));
		@(negedge clk_sys);
		bsram_write = 1'b1;
		@(negedge clk_sys);
		bsram_write = 1'b0;
		check_value("autosave led pending", 128'(1), 128'(led_user));
		osd_open = 1'b1;
		wait_busy_done("autosave", 1'b0);
		check_blocks("autosave", 1'b0, 16);
		check_value("autosave pending cleared", 128'(0), 128'(led_user));
		// Sequencer stays idle while the menu is still open
		idle_cycles(2);
		check_value("autosave busy end", 128'(0), 128'(bk_busy));
		osd_open = 1'b0;
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		reset       = 1'b0;
		load        = '0;
		hdr_mode    = HDR_AUTO;
		region_sel  = 2'd0;
		img         = '0;
		bk_load     = 1'b0;
		bk_save     = 1'b0;
		autosave    = 1'b0;
		osd_open    = 1'b0;
		bsram_write = 1'b0;
		sd_ack      = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk_sys);
		reset = 1'b1;
		idle_cycles(2);

		auto_header();
		forced_header();
		region_select();
		cheat_load();
		auto_load();
		menu_autosave();

		idle_cycles(4);
		errors += u_dut.u_backup.u_checker.fail_count;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, u_dut.u_backup.u_checker.fail_count);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* files.f */
hdl/cart_pkg.sv
hdl/backup_pkg.sv
hdl/rom_header_detect.sv
hdl/cheat_code_loader.sv
hdl/backup_ram_sync.sv
hdl/cart_loader_top.sv
testbench/backup_checker.sv
testbench/cart_loader_tb.sv

/* Makefile */
VERILATOR = verilator
TOP       = cart_loader_tb
FILE_LIST = files.f
BUILD_DIR = obj_dir
VFLAGS    = --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
SIM_ARGS  = +verilator+error+limit+1000
LOG       = sim.log
FAIL_MSG  = *** TEST FAILED ***
PASS_MSG  = *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG) || ! grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
